/* vlog.f */
source/jtag_pkg.sv
source/mem_bus_pkg.sv
source/tap_fsm.sv
source/instr_reg.sv
source/scan_regs.sv
source/mem_access.sv
source/jtag_mem_bridge.sv
verif/jtag_checker.sv
verif/tb_jtag_mem_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_jtag_mem_bridge
RTL_TOP   ?= jtag_mem_bridge
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_jtag_mem_bridge.sv */
module tb_jtag_mem_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    import jtag_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_ROWS = 13;
    localparam logic [1:0] K_FULL  = 2'd0;  // IR scan then DR scan
    localparam logic [1:0] K_DR    = 2'd1;  // DR scan with current instruction
    localparam logic [1:0] K_ABORT = 2'd2;  // Partial DR scan followed by tms high

    typedef struct packed {
        logic [1:0]  kind;
        logic [3:0]  code;
        logic [6:0]  len;
        logic [63:0] din;
        logic        chk;
        logic [63:0] exp;
        logic [7:0]  bsr;
        logic [7:0]  err;
        logic        cyc;
    } row_t;

    logic tck = 1'b0;
    logic trst_n, tms, tdi, tdo, wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
    logic [7:0]  bsr_in, bsr_out;
    logic [31:0] wb_adr, wb_dat_o, wb_dat_i;
    logic [3:0]  wb_sel;
    err_code_t   error_code;
    logic        check, exp_cycles, exp_we;
    logic [63:0] exp_tdo, tdo_mask;
    logic [7:0]  exp_bsr, exp_err;
    logic [31:0] exp_adr, exp_dat;
    logic [31:0] mem [256];
    int          row_idx, err_count, test_count, wait_left;
    int          seed = 75;
    row_t        rows [NUM_ROWS];

    always #2 tck = ~tck;

    jtag_mem_bridge u_jtag_mem_bridge (.*);
    jtag_checker u_jtag_checker (.*);

    // Memory model with a random ack delay and an err reply at one address
    always @(posedge tck) begin
        wb_ack <= 1'b0;
        wb_err <= 1'b0;
        if (!(wb_cyc && wb_stb)) begin
            wait_left <= $unsigned($random(seed)) % 4;
        end else if (!wb_ack && !wb_err) begin
            if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else if (wb_adr == 32'h000F_FF00) begin
                wb_err <= 1'b1;
            end else begin
                wb_ack <= 1'b1;
                if (wb_we) mem[wb_adr[9:2]] <= wb_dat_o;
                else wb_dat_i <= mem[wb_adr[9:2]];
            end
        end
    end

    task automatic step(input logic t, input logic d);
        @(posedge tck);
        tms <= t;
        tdi <= d;
    endtask

    task automatic shift_bits(input logic [63:0] v, input int n, input logic leave);
        for (int i = 0; i < n; i++) step(leave && i == n - 1, v[i]);
    endtask

    task automatic ir_scan(input logic [3:0] code);
        step(1, 0);
        step(1, 0);
        step(0, 0);
        step(0, 0);
        shift_bits(64'(code), 4, 1);
        step(1, 0);  // Update-IR
        step(0, 0);
    endtask

    task automatic dr_scan(input logic [63:0] v, input int n, input logic abort);
        step(1, 0);
        step(0, 0);
        step(0, 0);
        if (abort) begin
            shift_bits(v, n, 0);
            repeat (5) step(1, 0);  // Back to Test-Logic-Reset
        end else begin
            shift_bits(v, n, 1);
            step(1, 0);
        end
        step(0, 0);
    endtask

    initial begin
        repeat (NUM_ROWS * 200) @(posedge tck);
        $display("Watchdog expired before all rows finished");
        $display("test failed");
        $finish;
    end

    initial begin
        trst_n     = 1'b0;
        tms        = 1'b1;
        tdi        = 1'b0;
        bsr_in     = 8'h3C;
        wb_dat_i   = '0;
        wb_ack     = 1'b0;
        wb_err     = 1'b0;
        check      = 1'b0;
        row_idx    = 0;
        exp_tdo    = '0;
        tdo_mask   = '0;
        exp_bsr    = '0;
        exp_err    = '0;
        exp_cycles = 1'b0;
        exp_we     = 1'b0;
        exp_adr    = '0;
        exp_dat    = '0;
        for (int i = 0; i < 256; i++) mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0301);
        // kind, code, len, din, chk, expected tdo, bsr_out, error_code, bus cycles
        rows = '{
            '{K_DR, IDCODE, 32, 64'h0, 1, 64'(IDCODE_VALUE), 8'h00, ERR_NONE, 0},
            '{K_FULL, BYPASS, 8, 64'hA5, 1, 64'h4A, 8'h00, ERR_NONE, 0},
            '{K_FULL, 4'h3, 8, 64'h3C, 1, 64'h78, 8'h00, ERR_INVALID_INSTR, 0},
            '{K_FULL, SAMPLE_PRELOAD, 8, 64'h00, 1, 64'h3C, 8'h00, ERR_NONE, 0},
            '{K_FULL, EXTEST, 8, 64'h96, 1, 64'h3C, 8'h96, ERR_NONE, 0},
            '{K_FULL, MEM_WRITE, 64, 64'h40_CAFE_F00D, 0, 64'h0, 8'h96, ERR_NONE, 1},
            '{K_FULL, MEM_READ, 64, 64'h40_0000_0000, 1, 64'h40_0000_0000, 8'h96, ERR_NONE, 1},
            '{K_DR, MEM_READ, 64, 64'h40_0000_0000, 1, 64'h40_CAFE_F00D, 8'h96, ERR_NONE, 1},
            '{K_FULL, MEM_WRITE, 64, 64'h0010_0000_0000_0001, 1, 64'h40_CAFE_F00D, 8'h96,
              ERR_INVALID_ADDR, 0},
            '{K_FULL, MEM_READ, 64, 64'h000F_FF00_0000_0000, 1, 64'h0010_0000_CAFE_F00D,
              8'h96, ERR_BUS, 1},
            '{K_DR, MEM_READ, 64, 64'h40_0000_0000, 1, {32'h000F_FF00, ERR_PATTERN}, 8'h96,
              ERR_NONE, 1},
            '{K_ABORT, BYPASS, 4, 64'h0, 0, 64'h0, 8'h96, ERR_NONE, 0},
            '{K_DR, IDCODE, 32, 64'h0, 1, 64'(IDCODE_VALUE), 8'h96, ERR_NONE, 0}
        };
        repeat (10) @(posedge tck);
        trst_n <= 1'b1;
        step(0, 0);  // Run-Test/Idle
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].kind != K_DR) ir_scan(rows[r].code);
            dr_scan(rows[r].din, int'(rows[r].len), rows[r].kind == K_ABORT);
            @(posedge tck);  // Edge leaving Update-DR raises wb_cyc
            @(negedge tck);
            while (wb_cyc) @(negedge tck);
            @(posedge tck);
            row_idx    <= r;
            exp_tdo    <= rows[r].exp;
            tdo_mask   <= rows[r].chk ? (64'd1 << rows[r].len) - 64'd1 : 64'd0;
            exp_bsr    <= rows[r].bsr;
            exp_err    <= rows[r].err;
            exp_cycles <= rows[r].cyc;
            exp_we     <= rows[r].code == MEM_WRITE;
            exp_adr    <= rows[r].din[63:32];  // Shifted address and data
            exp_dat    <= rows[r].din[31:0];
            check      <= 1'b1;
            @(posedge tck);
            check <= 1'b0;
        end
        repeat (2) @(posedge tck);
        $display("tests run %0d, errors %0d", test_count, err_count);
        if (err_count == 0 && test_count == NUM_ROWS) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verif/jtag_checker.sv */
module jtag_checker (
    input  logic                   tck,
    input  logic                   trst_n,
    input  logic                   tms,
    input  logic                   tdo,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [31:0]            wb_adr,
    input  logic [31:0]            wb_dat_o,
    input  logic [3:0]             wb_sel,
    input  logic                   wb_ack,
    input  logic                   wb_err,
    input  logic [7:0]             bsr_out,
    input  mem_bus_pkg::err_code_t error_code,
    input  logic                   check,
    input  int                     row_idx,
    input  logic [63:0]            exp_tdo,
    input  logic [63:0]            tdo_mask,
    input  logic [7:0]             exp_bsr,
    input  logic [7:0]             exp_err,
    input  logic                   exp_cycles,
    input  logic                   exp_we,
    input  logic [31:0]            exp_adr,
    input  logic [31:0]            exp_dat,
    output int                     err_count,
    output int                     test_count
);
    timeunit 1ns;
    timeprecision 100ps;

    import jtag_pkg::*;

    tap_state_t  st;        // TAP state rebuilt from tms
    logic [63:0] dr_word;
    logic [3:0]  ir_word;
    int          dr_cnt;
    int          ir_cnt;
    int          cyc_cnt;   // Bus cycles since the last check
    logic        last_we;
    logic        last_stb;
    logic [3:0]  last_sel;
    logic [31:0] last_adr;
    logic [31:0] last_dat;
    bit          row_bad;

    function automatic tap_state_t next_tap(input tap_state_t s, input logic t);
        case (s)
            TEST_LOGIC_RESET: return t ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   return t ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       return t ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         return t ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         return t ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         return t ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         return t ? UPDATE_DR : SHIFT_DR;
            SELECT_IR_SCAN:   return t ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       return t ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         return t ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         return t ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         return t ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         return t ? UPDATE_IR : SHIFT_IR;
            default:          return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;  // Both updates
        endcase
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR row %0d %s expected %h got %h", row_idx, name, exp, got);
            err_count++;
            row_bad = 1'b1;
        end
    endtask

    initial begin
        err_count  = 0;
        test_count = 0;
        cyc_cnt    = 0;
        dr_cnt     = 0;
        ir_cnt     = 0;
    end

    always @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            st <= TEST_LOGIC_RESET;
        end else begin
            if (st == CAPTURE_DR) dr_cnt = 0;
            if (st == CAPTURE_IR) ir_cnt = 0;
            if (st == SHIFT_DR && dr_cnt < 64) begin
                dr_word[dr_cnt] = tdo;  // LSB first
                dr_cnt++;
            end
            if (st == SHIFT_IR && ir_cnt < 4) begin
                ir_word[ir_cnt] = tdo;
                ir_cnt++;
            end
            if (st == UPDATE_IR && ir_word !== IR_CAPTURE) begin
                $display("ERROR IR capture tdo expected %h got %h", IR_CAPTURE, ir_word);
                err_count++;
            end
            if (wb_cyc && (wb_ack || wb_err)) begin
                cyc_cnt++;
                last_we  = wb_we;
                last_stb = wb_stb;
                last_sel = wb_sel;
                last_adr = wb_adr;
                last_dat = wb_dat_o;
            end
            if (check) begin
                row_bad = 1'b0;
                compare("tdo", dr_word & tdo_mask, exp_tdo & tdo_mask);
                compare("bsr_out", 64'(bsr_out), 64'(exp_bsr));
                compare("error_code", 64'(error_code), 64'(exp_err));
                compare("wb_stb", 64'(wb_stb), 64'd0);  // Idle once the cycle is over
                compare("wb_cyc count", 64'(cyc_cnt), 64'(exp_cycles));
                if (exp_cycles && cyc_cnt == 1) begin
                    compare("wb_stb", 64'(last_stb), 64'd1);
                    compare("wb_sel", 64'(last_sel), 64'hF);  // Whole word access
                    compare("wb_adr", 64'(last_adr), 64'(exp_adr));
                    compare("wb_we", 64'(last_we), 64'(exp_we));
                    if (exp_we) compare("wb_dat_o", 64'(last_dat), 64'(exp_dat));
                end
                $display("row %0d %s", row_idx, row_bad ? "mismatch" : "ok");
                test_count++;
                cyc_cnt = 0;
            end
            st <= next_tap(st, tms);
        end
    end

endmodule

/* source/jtag_mem_bridge.sv */
module jtag_mem_bridge (
    input  logic                                   tck,
    input  logic                                   trst_n,
    input  logic                                   tms,
    input  logic                                   tdi,
    output logic                                   tdo,
    input  logic [jtag_pkg::BSR_WIDTH-1:0]         bsr_in,
    output logic [jtag_pkg::BSR_WIDTH-1:0]         bsr_out,
    output mem_bus_pkg::err_code_t                 error_code,
    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic                                   wb_we,
    output logic [mem_bus_pkg::ADDR_WIDTH-1:0]     wb_adr,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]     wb_dat_o,
    output logic [mem_bus_pkg::DATA_WIDTH/8-1:0]   wb_sel,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]     wb_dat_i,
    input  logic                                   wb_ack,
    input  logic                                   wb_err
);

    import jtag_pkg::*;
    import mem_bus_pkg::*;

    tap_state_t state;
    instr_t     instr;
    err_code_t  bus_err;
    logic       ir_shift_lsb;
    logic       instr_err;
    logic       scan_tdo;
    logic       mar_lsb;

    tap_fsm u_tap_fsm (
        .tck    (tck),
        .trst_n (trst_n),
        .tms    (tms),
        .state  (state)
    );

    instr_reg u_instr_reg (
        .tck          (tck),
        .trst_n       (trst_n),
        .tdi          (tdi),
        .state        (state),
        .ir_shift_lsb (ir_shift_lsb),
        .instr        (instr),
        .instr_err    (instr_err)
    );

    scan_regs u_scan_regs (
        .tck      (tck),
        .trst_n   (trst_n),
        .tdi      (tdi),
        .state    (state),
        .instr    (instr),
        .bsr_in   (bsr_in),
        .bsr_out  (bsr_out),
        .scan_tdo (scan_tdo)
    );

    mem_access u_mem_access (
        .tck      (tck),
        .trst_n   (trst_n),
        .tdi      (tdi),
        .state    (state),
        .instr    (instr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_sel   (wb_sel),
        .mar_lsb  (mar_lsb),
        .bus_err  (bus_err)
    );

    // TDO changes on the falling edge, half a clock ahead of the sampling edge
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo <= 1'b0;
        end else begin
            case (state)
                SHIFT_IR: tdo <= ir_shift_lsb;
                SHIFT_DR: tdo <= (instr == MEM_READ || instr == MEM_WRITE) ? mar_lsb : scan_tdo;
                default:  tdo <= 1'b0;
            endcase
        end
    end

    // A bad instruction outranks any bus status
    assign error_code = instr_err ? ERR_INVALID_INSTR : bus_err;

endmodule

/* source/mem_access.sv */
module mem_access (
    input  logic                                   tck,
    input  logic                                   trst_n,
    input  logic                                   tdi,
    input  jtag_pkg::tap_state_t                   state,
    input  jtag_pkg::instr_t                       instr,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]     wb_dat_i,
    input  logic                                   wb_ack,
    input  logic                                   wb_err,
    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic                                   wb_we,
    output logic [mem_bus_pkg::ADDR_WIDTH-1:0]     wb_adr,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]     wb_dat_o,
    output logic [mem_bus_pkg::DATA_WIDTH/8-1:0]   wb_sel,
    output logic                                   mar_lsb,
    output mem_bus_pkg::err_code_t                 bus_err
);

    import jtag_pkg::*;
    import mem_bus_pkg::*;

    logic [MAR_WIDTH-1:0]  mar;      // {address, data}
    logic [DATA_WIDTH-1:0] rd_data;  // Last read result
    logic [ADDR_WIDTH-1:0] mar_addr;
    logic [DATA_WIDTH-1:0] mar_data;
    logic [ADDR_WIDTH-1:0] addr_offset;
    logic                  mem_sel;
    logic                  in_window;
    logic                  do_update;
    logic                  cyc_done;

    assign mar_addr = mar[MAR_WIDTH-1:DATA_WIDTH];
    assign mar_data = mar[DATA_WIDTH-1:0];
    assign mar_lsb  = mar[0];

    assign mem_sel   = (instr == MEM_READ) || (instr == MEM_WRITE);
    assign do_update = mem_sel && (state == UPDATE_DR);
    assign cyc_done  = wb_cyc && (wb_ack || wb_err);

    // Offset wraps below the base, so one compare covers both bounds
    assign addr_offset = mar_addr - MEM_BASE;
    assign in_window   = addr_offset < MEM_SIZE;

    assign wb_sel = '1;  // Full word accesses only

    // Access register, address half is kept across captures
    always_ff @(posedge tck) begin
        if (mem_sel && state == CAPTURE_DR) begin
            mar[DATA_WIDTH-1:0] <= (bus_err == ERR_BUS) ? ERR_PATTERN : rd_data;
        end else if (mem_sel && state == SHIFT_DR) begin
            mar <= {tdi, mar[MAR_WIDTH-1:1]};
        end
    end

    // Address and write data held stable for the whole cycle
    always_ff @(posedge tck) begin
        if (do_update && !wb_cyc && in_window) begin
            wb_adr   <= mar_addr;
            wb_dat_o <= mar_data;
        end
    end

    // Bus master control and error tracking
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_we   <= 1'b0;
            rd_data <= '0;
            bus_err <= ERR_NONE;
        end else begin
            if (cyc_done) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
                if (wb_err) begin
                    bus_err <= ERR_BUS;
                end else begin
                    bus_err <= ERR_NONE;
                    if (!wb_we) begin
                        rd_data <= wb_dat_i;  // Read data taken on the ack edge
                    end
                end
            end

            // Update-DR starts the access on the edge leaving it
            if (do_update) begin
                if (wb_cyc) begin
                    bus_err <= ERR_BUSY;     // Previous cycle still open
                end else if (!in_window) begin
                    bus_err <= ERR_INVALID_ADDR;
                end else begin
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    wb_we  <= (instr == MEM_WRITE);
                end
            end
        end
    end

endmodule

/* source/scan_regs.sv */
module scan_regs (
    input  logic                             tck,
    input  logic                             trst_n,
    input  logic                             tdi,
    input  jtag_pkg::tap_state_t             state,
    input  jtag_pkg::instr_t                 instr,
    input  logic [jtag_pkg::BSR_WIDTH-1:0]   bsr_in,
    output logic [jtag_pkg::BSR_WIDTH-1:0]   bsr_out,
    output logic                             scan_tdo
);

    import jtag_pkg::*;

    logic [31:0]          idcode_sr;
    logic                 bypass_sr;
    logic [BSR_WIDTH-1:0] bsr_sr;
    logic                 bsr_sel;

    assign bsr_sel = (instr == SAMPLE_PRELOAD) || (instr == EXTEST);

    // IDCODE register, reloaded on every capture
    always_ff @(posedge tck) begin
        if (state == CAPTURE_DR) begin
            idcode_sr <= IDCODE_VALUE;
        end else if (state == SHIFT_DR && instr == IDCODE) begin
            idcode_sr <= {tdi, idcode_sr[31:1]};
        end
    end

    // Single-bit bypass stage
    always_ff @(posedge tck) begin
        if (state == CAPTURE_DR) begin
            bypass_sr <= 1'b0;
        end else if (state == SHIFT_DR) begin
            bypass_sr <= tdi;
        end
    end

    // Boundary scan shift stage
    always_ff @(posedge tck) begin
        if (bsr_sel) begin
            if (state == CAPTURE_DR) begin
                bsr_sr <= bsr_in;         // Sample the pins
            end else if (state == SHIFT_DR) begin
                bsr_sr <= {tdi, bsr_sr[BSR_WIDTH-1:1]};
            end
        end
    end

    // Boundary update stage drives the pins
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            bsr_out <= '0;
        end else if (bsr_sel && state == UPDATE_DR) begin
            bsr_out <= bsr_sr;
        end
    end

    always_comb begin
        case (instr)
            IDCODE:                 scan_tdo = idcode_sr[0];
            SAMPLE_PRELOAD, EXTEST: scan_tdo = bsr_sr[0];
            default:                scan_tdo = bypass_sr;
        endcase
    end

endmodule

/* source/instr_reg.sv */
module instr_reg (
    input  logic                 tck,
    input  logic                 trst_n,
    input  logic                 tdi,
    input  jtag_pkg::tap_state_t state,
    output logic                 ir_shift_lsb,
    output jtag_pkg::instr_t     instr,
    output logic                 instr_err
);

    import jtag_pkg::*;

    logic [IR_WIDTH-1:0] ir_shift;  // IR shift stage

    // Loaded in Capture-IR and shifted LSB first
    always_ff @(posedge tck) begin
        if (state == CAPTURE_IR) begin
            ir_shift <= IR_CAPTURE;
        end else if (state == SHIFT_IR) begin
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    assign ir_shift_lsb = ir_shift[0];

    // Update stage with decode check
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            instr     <= IDCODE;
            instr_err <= 1'b0;
        end else if (state == TEST_LOGIC_RESET) begin
            instr <= IDCODE;               // TAP reset selects IDCODE
        end else if (state == UPDATE_IR) begin
            case (ir_shift)
                BYPASS, IDCODE, SAMPLE_PRELOAD, EXTEST, MEM_READ, MEM_WRITE: begin
                    instr     <= instr_t'(ir_shift);
                    instr_err <= 1'b0;
                end
                default: begin
                    instr     <= BYPASS;   // Unknown code acts as BYPASS
                    instr_err <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* source/tap_fsm.sv */
module tap_fsm (
    input  logic                tck,
    input  logic                trst_n,
    input  logic                tms,
    output jtag_pkg::tap_state_t state
);

    import jtag_pkg::*;

    tap_state_t next_state;

    // Transition table of IEEE 1149.1, tms sampled on the rising edge
    always_comb begin
        case (state)
            TEST_LOGIC_RESET: next_state = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    next_state = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;

            // Data register column
            SELECT_DR_SCAN:   next_state = tms ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       next_state = tms ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         next_state = tms ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         next_state = tms ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         next_state = tms ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         next_state = tms ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        next_state = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;

            // Instruction register column
            SELECT_IR_SCAN:   next_state = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       next_state = tms ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         next_state = tms ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         next_state = tms ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         next_state = tms ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         next_state = tms ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        next_state = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;

            default:          next_state = TEST_LOGIC_RESET;
        endcase
    end

    // Five tms-high clocks reach Test-Logic-Reset from any state
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* source/mem_bus_pkg.sv */
package mem_bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Access register holds {address, data}
    localparam int MAR_WIDTH = ADDR_WIDTH + DATA_WIDTH;

    // Window reachable from the debug port
    localparam logic [ADDR_WIDTH-1:0] MEM_BASE = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] MEM_SIZE = 32'h0010_0000;  // 1 MiB

    // Error codes reported on error_code
    typedef enum logic [7:0] {
        ERR_NONE          = 8'h00,
        ERR_INVALID_ADDR  = 8'h01,
        ERR_BUS           = 8'h03,
        ERR_INVALID_INSTR = 8'h04,
        ERR_BUSY          = 8'h05
    } err_code_t;

    // Seen in the data half of the next capture after a bus error
    localparam logic [DATA_WIDTH-1:0] ERR_PATTERN = 32'hDEAD_BEEF;

endpackage

/* source/jtag_pkg.sv */
package jtag_pkg;

    // IEEE 1149.1 TAP controller states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'b0000,
        RUN_TEST_IDLE    = 4'b0001,
        SELECT_DR_SCAN   = 4'b0010,
        CAPTURE_DR       = 4'b0011,
        SHIFT_DR         = 4'b0100,
        EXIT1_DR         = 4'b0101,
        PAUSE_DR         = 4'b0110,
        EXIT2_DR         = 4'b0111,
        UPDATE_DR        = 4'b1000,
        SELECT_IR_SCAN   = 4'b1001,
        CAPTURE_IR       = 4'b1010,
        SHIFT_IR         = 4'b1011,
        EXIT1_IR         = 4'b1100,
        PAUSE_IR         = 4'b1101,
        EXIT2_IR         = 4'b1110,
        UPDATE_IR        = 4'b1111
    } tap_state_t;

    // Supported instructions, anything else decodes to BYPASS
    typedef enum logic [3:0] {
        EXTEST         = 4'b0000,
        IDCODE         = 4'b0001,
        SAMPLE_PRELOAD = 4'b0010,
        MEM_READ       = 4'b0100,
        MEM_WRITE      = 4'b0101,
        BYPASS         = 4'b1111  // Mandatory all-ones code
    } instr_t;

    localparam int IR_WIDTH = 4;
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0101;  // LSBs fixed at 01

    // Device identification, bit 0 set as the standard requires
    localparam logic [31:0] IDCODE_VALUE = 32'h1234_5679;

    localparam int BSR_WIDTH = 8;

endpackage
